// File: filelist.f
rtl/mpmc_pkg.sv
rtl/mpmc_apb_regs.sv
rtl/mpmc_ctrl.sv
rtl/mpmc_req_strip_cnt.sv
rtl/mpmc_strip_buf.sv
rtl/mpmc_mem_port.sv
rtl/mpmc_top.sv
verif/mpmc_chk.sv
verif/mpmc_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mpmc_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
FAIL_MSG  ?= Regression failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/mpmc_tb.sv
`timescale 1ns/1ps

module mpmc_tb;
	import mpmc_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int NUM_BURSTS = 15;
	localparam int TIMEOUT_NS = (NUM_BURSTS * 16 * 20 + 2000) * CLK_PERIOD;
	localparam int POLL_LIMIT = 400;

	logic        clk;
	logic        rst;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	mem_cmd_t    mem_cmd;
	logic        wdf_rdy;
	logic        rdy;
	logic [31:0] rdata;

	integer      seed;
	integer      bp_seed;
	int          rdy_pct;
	logic [31:0] model_mem [256];
	logic [31:0] shadow_buf [16];
	logic [7:0]  hs_addr_q [$];
	logic [31:0] hs_data_q [$];
	logic        hs_we_q [$];
	int          test_errs;
	int          total_errs;
	int          tests_run;
	int          tests_failed;

	mpmc_top #(.STRIP_CNT_W(4), .ADDR_W(8)) mpmc_top_inst (
		.clk(clk), .rst(rst), .apb_req(apb_req), .apb_rsp(apb_rsp),
		.mem_cmd(mem_cmd), .wdf_rdy(wdf_rdy), .rdy(rdy), .rdata(rdata)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// ====================
	// Memory model
	// ====================

	// Ready lines are redrawn each cycle and read data follows the presented address
	always @(posedge clk) begin
		#1;
		rdy     = ($unsigned($random(bp_seed)) % 100) < rdy_pct;
		wdf_rdy = ($unsigned($random(bp_seed)) % 100) < rdy_pct;
		rdata   = model_mem[mem_cmd.addr[7:0]];
	end

	// Handshakes are taken mid-cycle where every line is settled
	always @(negedge clk) begin
		if (!rst && mem_cmd.valid) begin
			if (mem_cmd.we && wdf_rdy) begin
				model_mem[mem_cmd.addr[7:0]] = mem_cmd.wdata;
				hs_addr_q.push_back(mem_cmd.addr[7:0]);
				hs_data_q.push_back(mem_cmd.wdata);
				hs_we_q.push_back(1'b1);
			end else if (!mem_cmd.we && rdy) begin
				hs_addr_q.push_back(mem_cmd.addr[7:0]);
				hs_data_q.push_back(rdata);
				hs_we_q.push_back(1'b0);
			end
		end
	end

	// ====================
	// Host tasks
	// ====================

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		assert (got === exp)
		else begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			test_errs++;
		end
	endtask

	// Runs one APB transfer of setup then access and takes the response in the access cycle
	task automatic apb_access(input logic wr, input logic [7:0] addr,
			input logic [31:0] wdata, output logic [31:0] rd, output logic err);
		@(posedge clk);
		#1;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = wr;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(posedge clk);
		#1;
		apb_req.penable = 1'b1;
		@(negedge clk);
		rd  = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		// No wait states, so ready must be up in every access cycle
		check_value(32'(apb_rsp.pready), 32'h1, "pready");
		@(posedge clk);
		#1;
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] rd_ignored;
		logic        err;
		apb_access(1'b1, addr, data, rd_ignored, err);
		check_value(32'(err), 32'h0, "pslverr on write");
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		logic err;
		apb_access(1'b0, addr, 32'h0, data, err);
		check_value(32'(err), 32'h0, "pslverr on read");
	endtask

	// The control word has go in bit 0, direction in bit 1 and the last strip index from bit 8
	function automatic logic [31:0] ctrl_word(input logic dir, input int n);
		logic [31:0] w;
		w = '0;
		w[CTRL_GO] = 1'b1;
		w[CTRL_DIR] = dir;
		w[CTRL_NUM_LSB +: 4] = n[3:0];
		return w;
	endfunction

	task automatic fill_buffer();
		logic [31:0] word;
		for (int i = 0; i < 16; i++) begin
			word = $random(seed);
			shadow_buf[i] = word;
			apb_write(BUF_BASE + 8'(4 * i), word);
		end
	endtask

	task automatic read_back();
		logic [31:0] word;
		for (int i = 0; i < 16; i++) begin
			apb_read(BUF_BASE + 8'(4 * i), word);
			check_value(word, shadow_buf[i], $sformatf("buffer word %0d", i));
		end
	endtask

	task automatic start_burst(input logic dir, input int n, input logic [7:0] base);
		hs_addr_q.delete();
		hs_data_q.delete();
		hs_we_q.delete();
		apb_write(REG_BASE, {24'h0, base});
		apb_write(REG_CTRL, ctrl_word(dir, n));
	endtask

	// Status is polled until done shows with busy low
	task automatic wait_done();
		logic [31:0] stat;
		int          polls;
		stat  = '0;
		polls = 0;
		while (!(stat[STAT_DONE] && !stat[STAT_BUSY]) && polls < POLL_LIMIT) begin
			apb_read(REG_STATUS, stat);
			polls++;
		end
		assert (stat[STAT_DONE] && !stat[STAT_BUSY])
		else begin
			$display("Burst never reported done within %0d status reads", POLL_LIMIT);
			test_errs++;
		end
	endtask

	// Strip i goes to base+i modulo 256 with one handshake each
	task automatic check_burst(input logic dir, input int n, input logic [7:0] base);
		logic [7:0] exp_addr;
		check_value(32'(hs_addr_q.size()), 32'(n + 1), "handshake count");
		for (int i = 0; i <= n; i++) begin
			exp_addr = base + 8'(i);
			if (i < hs_addr_q.size()) begin
				check_value(32'(hs_addr_q[i]), 32'(exp_addr), $sformatf("address %0d", i));
				check_value(32'(hs_we_q[i]), 32'(!dir), $sformatf("direction %0d", i));
				if (!dir)
					check_value(hs_data_q[i], shadow_buf[i], $sformatf("write data %0d", i));
			end
			// A read burst leaves memory word base+i in buffer word i
			if (dir)
				shadow_buf[i] = model_mem[exp_addr];
		end
	endtask

	task automatic run_burst(input logic dir, input int n, input logic [7:0] base);
		start_burst(dir, n, base);
		wait_done();
		check_burst(dir, n, base);
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errs == 0) begin
			$display("Test %0d %s: ok", tests_run, name);
		end else begin
			$display("Test %0d %s: %0d checks failed", tests_run, name, test_errs);
			tests_failed++;
			total_errs += test_errs;
		end
		test_errs = 0;
	endtask

	// ====================
	// Test sequence
	// ====================

	initial begin
		logic [31:0] word;
		logic        err;
		logic [7:0]  base;
		int          n;
		int          chk_fails;
		seed         = 51;
		bp_seed      = seed + 1;
		rdy_pct      = 60;
		test_errs    = 0;
		total_errs   = 0;
		tests_run    = 0;
		tests_failed = 0;
		rst          = 1'b1;
		apb_req      = '0;
		wdf_rdy      = 1'b0;
		rdy          = 1'b0;
		rdata        = '0;
		// Every memory word carries its own address in several forms
		for (int a = 0; a < 256; a++)
			model_mem[a] = {8'ha5, 8'(a), ~8'(a), 8'(a * 7)};
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;

		apb_read(REG_STATUS, word);
		check_value(word, 32'h0, "status after reset");
		fill_buffer();
		read_back();
		end_test("buffer access");

		for (int k = 0; k < 3; k++) begin
			fill_buffer();
			base = 8'($random(seed));
			n    = int'($unsigned($random(seed)) % 16);
			run_burst(1'b0, n, base);
		end
		end_test("write bursts");

		for (int k = 0; k < 3; k++) begin
			base = 8'($random(seed));
			n    = int'($unsigned($random(seed)) % 16);
			run_burst(1'b1, n, base);
			read_back();
		end
		end_test("read bursts");

		// Heavier stall so strips wait several cycles for ready
		rdy_pct = 30;
		for (int k = 0; k < 4; k++) begin
			base = 8'($random(seed));
			n    = int'($unsigned($random(seed)) % 16);
			if (k % 2 == 0)
				fill_buffer();
			run_burst(1'(k % 2), n, base);
			if (k % 2 == 1)
				read_back();
		end
		rdy_pct = 60;
		end_test("back-pressure");

		fill_buffer();
		run_burst(1'b0, 0, 8'hff);
		run_burst(1'b0, 15, 8'hfa);
		run_burst(1'b1, 15, 8'hfc);
		run_burst(1'b1, 0, 8'h80);
		read_back();
		end_test("burst length limits");

		fill_buffer();
		rdy_pct = 30;
		start_burst(1'b0, 15, 8'h20);
		apb_access(1'b1, BUF_BASE + 8'd12, 32'hdead_beef, word, err);
		check_value(32'(err), 32'h1, "pslverr on buffer write while busy");
		apb_access(1'b0, BUF_BASE + 8'd20, 32'h0, word, err);
		check_value(32'(err), 32'h1, "pslverr on buffer read while busy");
		apb_write(REG_CTRL, ctrl_word(1'b1, 2));
		wait_done();
		// Any burst started by the second go would add handshakes here
		repeat (40) @(posedge clk);
		check_burst(1'b0, 15, 8'h20);
		apb_read(REG_STATUS, word);
		check_value(32'(word[STAT_BUSY]), 32'h0, "busy after blocked go");
		rdy_pct = 60;
		read_back();
		end_test("access while busy");

		// The bound checker keeps its own count of failed assertions
		chk_fails = mpmc_top_inst.mpmc_chk_inst.fail_cnt;
		$display("Tests run %0d, tests failed %0d, checks failed %0d, assertion failures %0d",
			tests_run, tests_failed, total_errs, chk_fails);
		if (tests_failed == 0 && chk_fails == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired after %0d ns and the run did not finish", TIMEOUT_NS);
		$display("Regression failed");
		$finish;
	end

endmodule

// File: verif/mpmc_chk.sv
`timescale 1ns/1ps

module mpmc_chk (
	input logic                  clk,
	input logic                  rst,
	input mpmc_pkg::mpmc_state_t state,
	input mpmc_pkg::mem_cmd_t    mem_cmd,
	input logic                  wdf_rdy,
	input logic                  rdy,
	input logic                  burst_end
);
	import mpmc_pkg::*;

	logic stalled;
	int   fail_cnt = 0;

	// A command is stalled when the matching ready line is low
	assign stalled = mem_cmd.valid && (mem_cmd.we ? !wdf_rdy : !rdy);

	// Memory port stays quiet while no burst runs
	idle_quiet: assert property (@(posedge clk) disable iff (rst)
		(state == IDLE) |-> !mem_cmd.valid)
		else begin
			$error("valid high while the FSM is idle");
			fail_cnt++;
		end

	// Command held unchanged until the memory accepts it
	stall_stable: assert property (@(posedge clk) disable iff (rst)
		stalled |=> mem_cmd.valid && $stable(mem_cmd.we) && $stable(mem_cmd.addr)
			&& $stable(mem_cmd.wdata))
		else begin
			$error("memory command changed while stalled");
			fail_cnt++;
		end

	// The last handshake comes from a data state and hands over to DONE with valid dropped
	end_in_data: assert property (@(posedge clk) disable iff (rst)
		burst_end |=> (state == DONE) && !mem_cmd.valid
			&& ($past(state) == WRITE_DATA || $past(state) == READ_DATA))
		else begin
			$error("burst_end outside the data states or not followed by DONE");
			fail_cnt++;
		end

endmodule

bind mpmc_top mpmc_chk mpmc_chk_inst (
	.clk(clk), .rst(rst), .state(state), .mem_cmd(mem_cmd),
	.wdf_rdy(wdf_rdy), .rdy(rdy), .burst_end(burst_end)
);

// File: rtl/mpmc_top.sv
`timescale 1ns/1ps

module mpmc_top #(
	parameter int STRIP_CNT_W = 4,
	parameter int ADDR_W      = 8
) (
	input  logic               clk,
	input  logic               rst,
	input  mpmc_pkg::apb_req_t apb_req,
	output mpmc_pkg::apb_rsp_t apb_rsp,
	output mpmc_pkg::mem_cmd_t mem_cmd,
	input  logic               wdf_rdy,
	input  logic               rdy,
	input  logic [31:0]        rdata
);
	import mpmc_pkg::*;

	// ====================
	// Internal nets
	// ====================

	logic                   go;
	burst_cfg_t             cfg;
	mpmc_state_t            state;
	logic                   busy;
	logic                   done_set;
	logic [STRIP_CNT_W-1:0] strip_cnt;
	logic                   xfer;
	logic                   burst_end;

	// Host side of the buffer
	logic                   host_we;
	logic [STRIP_CNT_W-1:0] host_addr;
	logic [31:0]            host_wdata;
	logic [31:0]            host_rdata;

	// Memory side of the buffer, addressed by the strip counter
	logic                   mem_we;
	logic [31:0]            mem_wdata;
	logic [31:0]            mem_rdata;

	mpmc_apb_regs #(.STRIP_CNT_W(STRIP_CNT_W)) mpmc_apb_regs_inst (
		.clk(clk), .rst(rst), .apb_req(apb_req), .apb_rsp(apb_rsp),
		.busy(busy), .done_set(done_set), .strip_cnt(strip_cnt),
		.go(go), .cfg(cfg), .buf_we(host_we), .buf_addr(host_addr),
		.buf_wdata(host_wdata), .buf_rdata(host_rdata)
	);

	mpmc_ctrl mpmc_ctrl_inst (
		.clk(clk), .rst(rst), .go(go), .dir(cfg.dir), .burst_end(burst_end),
		.state(state), .busy(busy), .done_set(done_set)
	);

	mpmc_req_strip_cnt #(.STRIP_CNT_W(STRIP_CNT_W)) mpmc_req_strip_cnt_inst (
		.clk(clk), .state(state), .wdf_rdy(wdf_rdy), .rdy(rdy),
		.num_strips(cfg.num_strips), .strip_cnt(strip_cnt), .xfer(xfer),
		.burst_end(burst_end)
	);

	mpmc_strip_buf #(.STRIP_CNT_W(STRIP_CNT_W)) mpmc_strip_buf_inst (
		.clk(clk), .host_we(host_we), .host_addr(host_addr),
		.host_wdata(host_wdata), .host_rdata(host_rdata),
		.mem_we(mem_we), .mem_addr(strip_cnt), .mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

	mpmc_mem_port #(.STRIP_CNT_W(STRIP_CNT_W), .ADDR_W(ADDR_W)) mpmc_mem_port_inst (
		.clk(clk), .rst(rst), .state(state), .cfg(cfg), .strip_cnt(strip_cnt),
		.xfer(xfer), .buf_rdata(mem_rdata), .rdata(rdata), .mem_cmd(mem_cmd),
		.buf_we(mem_we), .buf_wdata(mem_wdata)
	);

endmodule

// File: rtl/mpmc_mem_port.sv
`timescale 1ns/1ps

module mpmc_mem_port #(
	parameter int STRIP_CNT_W = 4,
	parameter int ADDR_W      = 8
) (
	input  logic                   clk,
	input  logic                   rst,
	input  mpmc_pkg::mpmc_state_t  state,
	input  mpmc_pkg::burst_cfg_t   cfg,
	input  logic [STRIP_CNT_W-1:0] strip_cnt,
	input  logic                   xfer,
	input  logic [31:0]            buf_rdata,
	input  logic [31:0]            rdata,
	output mpmc_pkg::mem_cmd_t     mem_cmd,
	output logic                   buf_we,
	output logic [31:0]            buf_wdata
);
	import mpmc_pkg::*;

	logic              valid;
	logic              data_state;
	logic              last;
	logic [ADDR_W-1:0] addr_low;

	assign data_state = (state == WRITE_DATA) || (state == READ_DATA);
	assign last       = ({{(NUM_W-STRIP_CNT_W){1'b0}}, strip_cnt} == cfg.num_strips);

	// Valid rises out of PRESET so it lines up with the first data cycle
	// and drops right after the last strip completes
	always_ff @(posedge clk) begin
		if (rst)
			valid <= 1'b0;
		else
			valid <= (state == PRESET) || (data_state && !(xfer && last));
	end

	// Strip address wraps within the memory port's address range
	assign addr_low = cfg.base[ADDR_W-1:0] + {{(ADDR_W-STRIP_CNT_W){1'b0}}, strip_cnt};

	// Command fields only move on a handshake, which keeps them stable under stall
	always_comb begin
		mem_cmd.valid = valid;
		mem_cmd.we    = !cfg.dir;
		mem_cmd.addr  = {{(32-ADDR_W){1'b0}}, addr_low};
		mem_cmd.wdata = buf_rdata;
	end

	// Read data lands in the buffer at the current strip in the handshake cycle
	assign buf_we    = xfer && (state == READ_DATA);
	assign buf_wdata = rdata;

endmodule

// File: rtl/mpmc_strip_buf.sv
`timescale 1ns/1ps

module mpmc_strip_buf #(
	parameter int STRIP_CNT_W = 4
) (
	input  logic                   clk,
	input  logic                   host_we,
	input  logic [STRIP_CNT_W-1:0] host_addr,
	input  logic [31:0]            host_wdata,
	output logic [31:0]            host_rdata,
	input  logic                   mem_we,
	input  logic [STRIP_CNT_W-1:0] mem_addr,
	input  logic [31:0]            mem_wdata,
	output logic [31:0]            mem_rdata
);

	// One word per strip
	logic [31:0] words [2**STRIP_CNT_W];

	// ====================
	// Write port
	// ====================

	// Host and memory never write together, since host access is refused while busy
	// One shared write port is enough and the memory side wins by order only
	always_ff @(posedge clk) begin
		if (mem_we)
			words[mem_addr] <= mem_wdata;
		else if (host_we)
			words[host_addr] <= host_wdata;
	end

	// ====================
	// Read ports
	// ====================

	// Host reads are combinational to keep APB at zero wait states
	assign host_rdata = words[host_addr];

	// Write data for the memory follows the strip index in the same cycle
	assign mem_rdata = words[mem_addr];

endmodule

// File: rtl/mpmc_req_strip_cnt.sv
`timescale 1ns/1ps

module mpmc_req_strip_cnt #(
	parameter int STRIP_CNT_W = 4
) (
	input  logic                         clk,
	input  mpmc_pkg::mpmc_state_t        state,
	input  logic                         wdf_rdy,
	input  logic                         rdy,
	input  logic [mpmc_pkg::NUM_W-1:0]   num_strips,
	output logic [STRIP_CNT_W-1:0]       strip_cnt,
	output logic                         xfer,
	output logic                         burst_end
);
	import mpmc_pkg::*;

	logic             on;
	logic [NUM_W-1:0] cnt_ext;

	assign cnt_ext = {{(NUM_W-STRIP_CNT_W){1'b0}}, strip_cnt};

	// While armed the memory port holds valid high, so ready alone completes a strip
	assign xfer = on && (((state == WRITE_DATA) && wdf_rdy) || ((state == READ_DATA) && rdy));

	// Last handshake of the burst
	assign burst_end = xfer && (cnt_ext == num_strips);

	// The counter clears in IDLE and arms in PRESET
	always_ff @(posedge clk) begin
		if (state == IDLE) begin
			strip_cnt <= '0;
			on        <= 1'b0;
		end else begin
			if (state == PRESET)
				on <= 1'b1;
			if (xfer) begin
				// Hold the index on the last strip so status shows where the burst ended
				if (burst_end)
					on <= 1'b0;
				else
					strip_cnt <= strip_cnt + STRIP_CNT_W'(1);
			end
		end
	end

endmodule

// File: rtl/mpmc_ctrl.sv
`timescale 1ns/1ps

module mpmc_ctrl (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  go,
	input  logic                  dir,
	input  logic                  burst_end,
	output mpmc_pkg::mpmc_state_t state,
	output logic                  busy,
	output logic                  done_set
);
	import mpmc_pkg::*;

	mpmc_state_t state_nxt;

	// ====================
	// Next state
	// ====================

	// One pass through the burst, with PRESET giving the counter a cycle to arm
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (go)
					state_nxt = PRESET;
			end
			PRESET: begin
				// Direction comes from the setup latched with go
				state_nxt = dir ? READ_DATA : WRITE_DATA;
			end
			WRITE_DATA: begin
				if (burst_end)
					state_nxt = DONE;
			end
			READ_DATA: begin
				if (burst_end)
					state_nxt = DONE;
			end
			DONE: begin
				state_nxt = IDLE;
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// Busy covers the whole burst, DONE included, so the host sees done with busy low
	assign busy     = (state != IDLE);
	assign done_set = (state == DONE);

endmodule

// File: rtl/mpmc_apb_regs.sv
`timescale 1ns/1ps

module mpmc_apb_regs #(
	parameter int STRIP_CNT_W = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  mpmc_pkg::apb_req_t     apb_req,
	output mpmc_pkg::apb_rsp_t     apb_rsp,
	input  logic                   busy,
	input  logic                   done_set,
	input  logic [STRIP_CNT_W-1:0] strip_cnt,
	output logic                   go,
	output mpmc_pkg::burst_cfg_t   cfg,
	output logic                   buf_we,
	output logic [STRIP_CNT_W-1:0] buf_addr,
	output logic [31:0]            buf_wdata,
	input  logic [31:0]            buf_rdata
);
	import mpmc_pkg::*;

	logic        access;
	logic        wr_access;
	logic        is_buf;
	logic [7:0]  buf_off;
	logic [31:0] base;
	logic        done;
	logic [31:0] ctrl_word;
	logic [31:0] status_word;

	// The access phase is the second cycle of a transfer, and pready is always high
	assign access    = apb_req.psel && apb_req.penable;
	assign wr_access = access && apb_req.pwrite;

	// Buffer window starts at BUF_BASE and holds one word per strip
	assign buf_off = apb_req.paddr - BUF_BASE;
	assign is_buf  = (apb_req.paddr >= BUF_BASE) && (buf_off[7:2] < 2**STRIP_CNT_W);

	// A start request while a burst runs is simply dropped
	assign go = wr_access && (apb_req.paddr == REG_CTRL) && apb_req.pwdata[CTRL_GO] && !busy;

	// The memory side owns the buffer during a burst
	assign buf_we    = wr_access && is_buf && !busy;
	assign buf_addr  = buf_off[2 +: STRIP_CNT_W];
	assign buf_wdata = apb_req.pwdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			base <= '0;
			cfg  <= '0;
			done <= 1'b0;
		end else begin
			if (wr_access && (apb_req.paddr == REG_BASE))
				base <= apb_req.pwdata;
			// Strip count is limited to what the buffer can hold
			if (go) begin
				cfg.dir        <= apb_req.pwdata[CTRL_DIR];
				cfg.num_strips <= {{(NUM_W-STRIP_CNT_W){1'b0}},
					apb_req.pwdata[CTRL_NUM_LSB +: STRIP_CNT_W]};
				cfg.base       <= base;
			end
			// Done stays set until the next burst is started
			if (go)
				done <= 1'b0;
			else if (done_set)
				done <= 1'b1;
		end
	end

	// Read-back words
	always_comb begin
		ctrl_word = '0;
		ctrl_word[CTRL_DIR] = cfg.dir;
		ctrl_word[CTRL_NUM_LSB +: NUM_W] = cfg.num_strips;
		status_word = '0;
		status_word[STAT_BUSY] = busy;
		status_word[STAT_DONE] = done;
		status_word[STAT_CNT_LSB +: STRIP_CNT_W] = strip_cnt;
	end

	// Read data is decoded straight from the address with zero wait states
	always_comb begin
		apb_rsp.pready  = 1'b1;
		apb_rsp.pslverr = access && is_buf && busy;
		case (apb_req.paddr)
			REG_CTRL:   apb_rsp.prdata = ctrl_word;
			REG_BASE:   apb_rsp.prdata = base;
			REG_STATUS: apb_rsp.prdata = status_word;
			default:    apb_rsp.prdata = (is_buf && !busy) ? buf_rdata : '0;
		endcase
	end

endmodule

// File: rtl/mpmc_pkg.sv
package mpmc_pkg;

	// ====================
	// Control state
	// ====================

	// Burst sequencing states shared by the FSM, the counter and the memory port
	typedef enum logic [2:0] {
		IDLE,
		PRESET,
		WRITE_DATA,
		READ_DATA,
		DONE
	} mpmc_state_t;

	// ====================
	// Bus and burst types
	// ====================

	// Width of the last-strip index field in the burst setup
	localparam int NUM_W = 6;

	// One command word toward the memory, with the address kept at full width
	typedef struct packed {
		logic        valid;
		logic        we;
		logic [31:0] addr;
		logic [31:0] wdata;
	} mem_cmd_t;

	// Burst setup latched when the host starts a burst (dir set means read)
	typedef struct packed {
		logic             dir;
		logic [NUM_W-1:0] num_strips;
		logic [31:0]      base;
	} burst_cfg_t;

	// APB request as the host drives it
	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	// APB response back to the host
	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// Buffer word i sits at BUF_BASE + 4*i in the register map
	localparam logic [7:0] REG_CTRL   = 8'h00;
	localparam logic [7:0] REG_BASE   = 8'h04;
	localparam logic [7:0] REG_STATUS = 8'h08;
	localparam logic [7:0] BUF_BASE   = 8'h40;

	// Bit positions inside the control and status words
	localparam int CTRL_GO      = 0;
	localparam int CTRL_DIR     = 1;
	localparam int CTRL_NUM_LSB = 8;
	localparam int STAT_BUSY    = 0;
	localparam int STAT_DONE    = 1;
	localparam int STAT_CNT_LSB = 8;

endpackage
